// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cgra_array
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// File: design/cgra_array.sv
// CGRA top level: torus of cells, one memory arbiter and one
// result register block per column, global stall
`timescale 1ns/1ps
`default_nettype none

module cgra_array
  import cgra_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  instr_word_t      conf_words_i [N_ROW],
  input  logic [N_COL-1:0] conf_we_i,
  input  creg_idx_t        pc_i,
  input  logic             pc_en_i,
  input  logic [N_COL-1:0] data_gnt_i,
  input  logic [N_COL-1:0] data_rvalid_i,
  input  dp_word_t         data_rdata_i [N_COL],
  output logic [N_COL-1:0] data_req_o,
  output logic [N_COL-1:0] data_we_o,
  output mem_addr_t        data_add_o [N_COL],
  output dp_word_t         data_wdata_o [N_COL],
  output logic             stall_o
);

  // Everything per column is indexed [col][row]
  row_mask_t   col_req   [N_COL];
  row_mask_t   col_we    [N_COL];
  mem_addr_t   col_add   [N_COL][N_ROW];
  dp_word_t    col_wdata [N_COL][N_ROW];
  commit_sel_e col_csel  [N_COL][N_ROW];
  dp_word_t    col_alu   [N_COL][N_ROW];
  dp_word_t    col_res   [N_COL][N_ROW];
  row_mask_t   col_rv    [N_COL];
  logic [N_COL-1:0] col_busy;

  // ----------------------------------------------------------------------
  // Cells with torus wrap-around at all four edges
  // ----------------------------------------------------------------------
  for (genvar j = 0; j < N_COL; j++) begin : g_col
    localparam int LEFT  = (j + N_COL - 1) % N_COL;
    localparam int RIGHT = (j + 1) % N_COL;

    for (genvar i = 0; i < N_ROW; i++) begin : g_row
      localparam int TOP    = (i + N_ROW - 1) % N_ROW;
      localparam int BOTTOM = (i + 1) % N_ROW;

      reconfigurable_cell u_cell (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .conf_we_i    (conf_we_i[j]),
        .conf_word_i  (conf_words_i[i]),
        .pc_i         (pc_i),
        .own_res_i    (col_res[j][i]),
        .left_res_i   (col_res[LEFT][i]),
        .right_res_i  (col_res[RIGHT][i]),
        .top_res_i    (col_res[j][TOP]),
        .bottom_res_i (col_res[j][BOTTOM]),
        .alu_res_o    (col_alu[j][i]),
        .commit_sel_o (col_csel[j][i]),
        .data_req_o   (col_req[j][i]),
        .data_we_o    (col_we[j][i]),
        .data_add_o   (col_add[j][i]),
        .data_wdata_o (col_wdata[j][i])
      );
    end

    rc_mem_arbiter u_arb (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .pc_en_i      (pc_en_i),
      .req_i        (col_req[j]),
      .we_i         (col_we[j]),
      .add_i        (col_add[j]),
      .wdata_i      (col_wdata[j]),
      .gnt_i        (data_gnt_i[j]),
      .rvalid_i     (data_rvalid_i[j]),
      .data_req_o   (data_req_o[j]),
      .data_we_o    (data_we_o[j]),
      .data_add_o   (data_add_o[j]),
      .data_wdata_o (data_wdata_o[j]),
      .rvalid_row_o (col_rv[j]),
      .busy_o       (col_busy[j])
    );

    rc_result_regs u_res (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .pc_en_i      (pc_en_i),
      .commit_sel_i (col_csel[j]),
      .alu_res_i    (col_alu[j]),
      .rvalid_row_i (col_rv[j]),
      .rdata_i      (data_rdata_i[j]),
      .res_o        (col_res[j])
    );
  end

  // Controller must hold the step while any column is busy
  assign stall_o = |col_busy;

endmodule

`default_nettype wire

// File: design/cgra_pkg.sv
// Array dimensions, data and address widths, instruction field layout
// and the shared vector types and enums of the CGRA
`default_nettype none

package cgra_pkg;

  // ----------------------------------------------------------------------
  // Array size and widths
  // ----------------------------------------------------------------------
  localparam int N_ROW       = 3;
  localparam int N_COL       = 3;
  localparam int N_CREG      = 8;
  localparam int CREG_IDX_W  = 3;
  localparam int DP_WIDTH    = 16;
  localparam int ADDR_WIDTH  = 8;
  localparam int IMM_WIDTH   = 7;
  localparam int INSTR_WIDTH = 16;

  // ----------------------------------------------------------------------
  // Instruction word layout, MSB first
  // ----------------------------------------------------------------------
  localparam int OP_WIDTH  = 3;
  localparam int SRC_WIDTH = 3;

  localparam int OP_MSB   = INSTR_WIDTH - 1;
  localparam int OP_LSB   = OP_MSB - OP_WIDTH + 1;
  localparam int SRCA_MSB = OP_LSB - 1;
  localparam int SRCA_LSB = SRCA_MSB - SRC_WIDTH + 1;
  localparam int SRCB_MSB = SRCA_LSB - 1;
  localparam int SRCB_LSB = SRCB_MSB - SRC_WIDTH + 1;
  localparam int IMM_MSB  = IMM_WIDTH - 1;
  localparam int IMM_LSB  = 0;

  typedef logic [DP_WIDTH-1:0]    dp_word_t;
  typedef logic [ADDR_WIDTH-1:0]  mem_addr_t;
  typedef logic [INSTR_WIDTH-1:0] instr_word_t;
  typedef logic [CREG_IDX_W-1:0]  creg_idx_t;
  typedef logic [N_ROW-1:0]       row_mask_t;

  // All eight codes are used, NOP must stay at zero
  typedef enum logic [OP_WIDTH-1:0] {
    OP_NOP = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_OR  = 3'd4,
    OP_XOR = 3'd5,
    OP_LWI = 3'd6,
    OP_SWI = 3'd7
  } rc_op_e;

  // Codes 6 and 7 are unassigned and read as zero
  typedef enum logic [SRC_WIDTH-1:0] {
    SRC_OWN    = 3'd0,
    SRC_LEFT   = 3'd1,
    SRC_RIGHT  = 3'd2,
    SRC_TOP    = 3'd3,
    SRC_BOTTOM = 3'd4,
    SRC_IMM    = 3'd5
  } src_sel_e;

  typedef enum logic [1:0] {
    COMMIT_KEEP = 2'd0,
    COMMIT_ALU  = 2'd1,
    COMMIT_LOAD = 2'd2
  } commit_sel_e;

endpackage

`default_nettype wire

// File: design/rc_alu.sv
// Arithmetic and logic unit of one reconfigurable cell
`timescale 1ns/1ps
`default_nettype none

module rc_alu
  import cgra_pkg::*;
(
  input  rc_op_e   op_i,
  input  dp_word_t a_i,
  input  dp_word_t b_i,
  output dp_word_t result_o
);

  // 16-bit wrap-around arithmetic, carries are dropped
  always_comb begin
    case (op_i)
      OP_ADD: begin
        result_o = a_i + b_i;
      end
      OP_SUB: begin
        result_o = a_i - b_i;
      end
      OP_AND: begin
        result_o = a_i & b_i;
      end
      OP_OR: begin
        result_o = a_i | b_i;
      end
      OP_XOR: begin
        result_o = a_i ^ b_i;
      end
      // NOP, LWI and SWI pass operand A, the commit select ignores it
      default: begin
        result_o = a_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rc_mem_arbiter.sv
// Per-column memory arbiter: grant and rvalid masks, lowest-row
// selection, port multiplexing and rvalid routing back to the rows
`timescale 1ns/1ps
`default_nettype none

module rc_mem_arbiter
  import cgra_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      pc_en_i,
  input  row_mask_t req_i,
  input  row_mask_t we_i,
  input  mem_addr_t add_i [N_ROW],
  input  dp_word_t  wdata_i [N_ROW],
  input  logic      gnt_i,
  input  logic      rvalid_i,
  output logic      data_req_o,
  output logic      data_we_o,
  output mem_addr_t data_add_o,
  output dp_word_t  data_wdata_o,
  output row_mask_t rvalid_row_o,
  output logic      busy_o
);

  // A set mask bit means the row still waits for grant or for read data
  row_mask_t gnt_mask;
  row_mask_t rv_mask;
  row_mask_t req_pend;
  row_mask_t sel_row;
  row_mask_t rd_pend;
  row_mask_t rv_row;

  function automatic row_mask_t lowest_one(input row_mask_t m);
    return m & (~m + row_mask_t'(1));
  endfunction

  // ----------------------------------------------------------------------
  // Request side
  // ----------------------------------------------------------------------
  assign req_pend   = req_i & gnt_mask;
  assign sel_row    = lowest_one(req_pend);
  assign data_req_o = |req_pend;

  // One-hot selection of the served row onto the port
  always_comb begin
    data_we_o    = 1'b0;
    data_add_o   = '0;
    data_wdata_o = '0;
    for (int r = 0; r < N_ROW; r++) begin
      if (sel_row[r]) begin
        data_we_o    = we_i[r];
        data_add_o   = add_i[r];
        data_wdata_o = wdata_i[r];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read data side
  // ----------------------------------------------------------------------
  // Granted readers still waiting, data returns in grant order
  assign rd_pend      = req_i & ~we_i & ~gnt_mask & rv_mask;
  assign rv_row       = lowest_one(rd_pend);
  assign rvalid_row_o = rvalid_i ? rv_row : '0;

  assign busy_o = (|req_pend) | (|rd_pend);

  // Masks rearm on every step
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_mask <= '1;
      rv_mask  <= '1;
    end else if (pc_en_i) begin
      gnt_mask <= '1;
      rv_mask  <= '1;
    end else begin
      if (gnt_i) begin
        gnt_mask <= gnt_mask & ~sel_row;
      end
      if (rvalid_i) begin
        rv_mask <= rv_mask & ~rv_row;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/rc_result_regs.sv
// Result registers and load buffers of one column of cells
`timescale 1ns/1ps
`default_nettype none

module rc_result_regs
  import cgra_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        pc_en_i,
  input  commit_sel_e commit_sel_i [N_ROW],
  input  dp_word_t    alu_res_i [N_ROW],
  input  row_mask_t   rvalid_row_i,
  input  dp_word_t    rdata_i,
  output dp_word_t    res_o [N_ROW]
);

  dp_word_t ld_buf [N_ROW];
  dp_word_t res_q  [N_ROW];

  // Read data parked until the step commits
  always_ff @(posedge clk_i) begin
    for (int r = 0; r < N_ROW; r++) begin
      if (rvalid_row_i[r]) begin
        ld_buf[r] <= rdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < N_ROW; r++) begin
        res_q[r] <= '0;
      end
    end else if (pc_en_i) begin
      for (int r = 0; r < N_ROW; r++) begin
        case (commit_sel_i[r])
          COMMIT_ALU:  res_q[r] <= alu_res_i[r];
          COMMIT_LOAD: res_q[r] <= ld_buf[r];
          default:     res_q[r] <= res_q[r];
        endcase
      end
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

// File: design/reconfigurable_cell.sv
// One CGRA cell: configuration memory, instruction decode,
// operand selection from the torus and memory request generation
`timescale 1ns/1ps
`default_nettype none

module reconfigurable_cell
  import cgra_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        conf_we_i,
  input  instr_word_t conf_word_i,
  input  creg_idx_t   pc_i,
  input  dp_word_t    own_res_i,
  input  dp_word_t    left_res_i,
  input  dp_word_t    right_res_i,
  input  dp_word_t    top_res_i,
  input  dp_word_t    bottom_res_i,
  output dp_word_t    alu_res_o,
  output commit_sel_e commit_sel_o,
  output logic        data_req_o,
  output logic        data_we_o,
  output mem_addr_t   data_add_o,
  output dp_word_t    data_wdata_o
);

  instr_word_t          conf_mem [N_CREG];
  instr_word_t          instr;
  rc_op_e               op;
  src_sel_e             sel_a;
  src_sel_e             sel_b;
  logic [IMM_WIDTH-1:0] imm;
  dp_word_t             op_a;
  dp_word_t             op_b;

  function automatic dp_word_t pick_operand(
    input src_sel_e sel,
    input logic [IMM_WIDTH-1:0] imm_val,
    input dp_word_t own,
    input dp_word_t left,
    input dp_word_t right,
    input dp_word_t top,
    input dp_word_t bottom
  );
    case (sel)
      SRC_OWN:    return own;
      SRC_LEFT:   return left;
      SRC_RIGHT:  return right;
      SRC_TOP:    return top;
      SRC_BOTTOM: return bottom;
      SRC_IMM:    return dp_word_t'(imm_val);
      default:    return '0;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Configuration memory, cleared to NOP words
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < N_CREG; w++) begin
        conf_mem[w] <= '0;
      end
    end else if (conf_we_i) begin
      conf_mem[pc_i] <= conf_word_i;
    end
  end

  // ----------------------------------------------------------------------
  // Decode of the current word
  // ----------------------------------------------------------------------
  assign instr = conf_mem[pc_i];
  assign op    = rc_op_e'(instr[OP_MSB:OP_LSB]);
  assign sel_a = src_sel_e'(instr[SRCA_MSB:SRCA_LSB]);
  assign sel_b = src_sel_e'(instr[SRCB_MSB:SRCB_LSB]);
  assign imm   = instr[IMM_MSB:IMM_LSB];

  assign op_a = pick_operand(sel_a, imm, own_res_i, left_res_i, right_res_i,
                             top_res_i, bottom_res_i);
  assign op_b = pick_operand(sel_b, imm, own_res_i, left_res_i, right_res_i,
                             top_res_i, bottom_res_i);

  rc_alu u_alu (
    .op_i     (op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_res_o)
  );

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: commit_sel_o = COMMIT_ALU;
      OP_LWI:                                commit_sel_o = COMMIT_LOAD;
      default:                               commit_sel_o = COMMIT_KEEP;
    endcase
  end

  // Memory access uses the immediate as word address
  assign data_req_o   = (op == OP_LWI) || (op == OP_SWI);
  assign data_we_o    = (op == OP_SWI);
  assign data_add_o   = mem_addr_t'(imm);
  assign data_wdata_o = op_a;

endmodule

`default_nettype wire

// File: verification/cgra_array_properties.sv
// Concurrent checks on the per-column memory arbiter
`timescale 1ns/1ps
`default_nettype none

module cgra_array_properties
  import cgra_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      pc_en_i,
  input logic      gnt_i,
  input row_mask_t req_i,
  input row_mask_t sel_row_i,
  input logic      port_req_i,
  input logic      busy_i
);

  // Port request holds until granted, unless the rows' requests change
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    port_req_i && !gnt_i && !pc_en_i |=> port_req_i || (req_i != $past(req_i)))
    else $error("arbiter dropped an ungranted request");

  // A served row is masked and not selected again within the step
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_i && !pc_en_i |=> (sel_row_i & $past(sel_row_i)) == '0)
    else $error("row selected again after its grant");

  // Configuration is all NOP right after reset
  assert property (@(posedge clk_i) $rose(arst_n_i) |-> !busy_i)
    else $error("arbiter busy right after reset");

endmodule

bind rc_mem_arbiter cgra_array_properties u_props (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .pc_en_i    (pc_en_i),
  .gnt_i      (gnt_i),
  .req_i      (req_i),
  .sel_row_i  (sel_row),
  .port_req_i (data_req_o),
  .busy_i     (busy_o)
);

`default_nettype wire

// File: verification/tb_cgra_array.sv
// Testbench for the CGRA array: clock, reset, column memories,
// reference model of the torus, directed and random programs, report
`timescale 1ns/1ps
`default_nettype none

module tb_cgra_array;
  import cgra_pkg::*;

  localparam int N_STEPS    = 39;
  localparam int N_LOADS    = 6;
  localparam int STEP_BOUND = 40;

  logic             clk_i;
  logic             arst_n_i;
  instr_word_t      conf_words_i [N_ROW];
  logic [N_COL-1:0] conf_we_i;
  creg_idx_t        pc_i;
  logic             pc_en_i;
  logic [N_COL-1:0] data_gnt_i;
  logic [N_COL-1:0] data_rvalid_i;
  dp_word_t         data_rdata_i [N_COL];
  logic [N_COL-1:0] data_req_o;
  logic [N_COL-1:0] data_we_o;
  mem_addr_t        data_add_o [N_COL];
  dp_word_t         data_wdata_o [N_COL];
  logic             stall_o;

  dp_word_t         mem       [N_COL][256];
  dp_word_t         model_mem [N_COL][256];
  dp_word_t         model_res [N_ROW][N_COL];
  instr_word_t      prog      [N_CREG][N_ROW][N_COL];
  // Expected accesses per column in grant order: {we, addr, data}
  logic [24:0]      exp_q     [N_COL][$];
  logic [N_COL-1:0] rd_pend = '0;
  mem_addr_t        rd_addr [N_COL];
  logic             run_en;
  logic             delay_en;
  int               errors;
  int               tests;
  int               failed;
  int               grants;

  cgra_array DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Memory model: random grant delay, rvalid one cycle after a read
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    #1;
    for (int j = 0; j < N_COL; j++) begin
      data_gnt_i[j]    = run_en && data_req_o[j] && (!delay_en || ($urandom % 3) == 0);
      data_rvalid_i[j] = rd_pend[j];
      data_rdata_i[j]  = mem[j][rd_addr[j]];
    end
  end

  // Every granted access is compared with the reference in grant order
  always @(posedge clk_i) begin
    logic [24:0] e;
    for (int j = 0; j < N_COL; j++) begin
      rd_pend[j] <= 1'b0;
      if (data_req_o[j] && data_gnt_i[j]) begin
        grants++;
        if (exp_q[j].size() == 0) begin
          errors++;
          $display("FAIL %0t: column %0d granted an access the model does not expect",
                   $time, j);
        end else begin
          e = exp_q[j].pop_front();
          if (e[24] != data_we_o[j] || e[23:16] != data_add_o[j] ||
              (e[24] && e[15:0] != data_wdata_o[j])) begin
            errors++;
            $display("FAIL %0t: column %0d got we %0b addr %h data %h, expected %0b %h %h",
                     $time, j, data_we_o[j], data_add_o[j], data_wdata_o[j],
                     e[24], e[23:16], e[15:0]);
          end
        end
        if (data_we_o[j]) begin
          mem[j][data_add_o[j]] <= data_wdata_o[j];
        end else begin
          rd_pend[j] <= 1'b1;
          rd_addr[j] <= data_add_o[j];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic dp_word_t operand(input logic [2:0] sel, input logic [6:0] imm,
                                       input int r, input int c);
    case (sel)
      3'd0: return model_res[r][c];
      3'd1: return model_res[r][(c + N_COL - 1) % N_COL];
      3'd2: return model_res[r][(c + 1) % N_COL];
      3'd3: return model_res[(r + N_ROW - 1) % N_ROW][c];
      3'd4: return model_res[(r + 1) % N_ROW][c];
      3'd5: return {9'd0, imm};
      default: return '0;
    endcase
  endfunction

  // One step of the model array, accesses of a column in row order
  function automatic void ref_step(input int p);
    dp_word_t    nxt [N_ROW][N_COL];
    instr_word_t w;
    dp_word_t    a;
    dp_word_t    b;
    mem_addr_t   ad;
    for (int c = 0; c < N_COL; c++) begin
      for (int r = 0; r < N_ROW; r++) begin
        w = prog[p][r][c];
        a = operand(w[12:10], w[6:0], r, c);
        b = operand(w[9:7], w[6:0], r, c);
        ad = {1'b0, w[6:0]};
        nxt[r][c] = model_res[r][c];
        case (w[15:13])
          3'd1: nxt[r][c] = a + b;
          3'd2: nxt[r][c] = a - b;
          3'd3: nxt[r][c] = a & b;
          3'd4: nxt[r][c] = a | b;
          3'd5: nxt[r][c] = a ^ b;
          3'd6: begin
            exp_q[c].push_back({1'b0, ad, 16'h0000});
            nxt[r][c] = model_mem[c][ad];
          end
          3'd7: begin
            exp_q[c].push_back({1'b1, ad, a});
            model_mem[c][ad] = a;
          end
          default: ;
        endcase
      end
    end
    model_res = nxt;
  endfunction

  function automatic instr_word_t word(input int op, input int sa, input int sb,
                                       input int imm);
    return {3'(op), 3'(sa), 3'(sb), 7'(imm)};
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic load_prog();
    for (int p = 0; p < N_CREG; p++) begin
      for (int c = 0; c < N_COL; c++) begin
        @(negedge clk_i);
        pc_i = creg_idx_t'(p);
        for (int r = 0; r < N_ROW; r++) begin
          conf_words_i[r] = prog[p][r][c];
        end
        conf_we_i = N_COL'(1) << c;
      end
    end
    @(negedge clk_i);
    conf_we_i = '0;
  endtask

  task automatic run_step(input int p);
    @(negedge clk_i);
    pc_i = creg_idx_t'(p);
    ref_step(p);
    run_en = 1'b1;
    do begin
      @(negedge clk_i);
      for (int c = 0; c < N_COL; c++) begin
        if (exp_q[c].size() != 0 && !stall_o) begin
          errors++;
          $display("FAIL %0t: stall low while column %0d has accesses left", $time, c);
        end
      end
    end while (stall_o);
    run_en = 1'b0;
    for (int c = 0; c < N_COL; c++) begin
      if (exp_q[c].size() != 0) begin
        errors++;
        $display("FAIL %0t: step %0d ended with column %0d accesses missing", $time, p, c);
        exp_q[c].delete();
      end
    end
    pc_en_i = 1'b1;
    @(negedge clk_i);
    pc_en_i = 1'b0;
  endtask

  task automatic check_mem();
    for (int c = 0; c < N_COL; c++) begin
      for (int a = 0; a < 256; a++) begin
        if (mem[c][a] != model_mem[c][a]) begin
          errors++;
          $display("FAIL %0t: memory %0d word %h is %h, expected %h",
                   $time, c, a, mem[c][a], model_mem[c][a]);
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    check_mem();
    if (errors != err_before) begin
      failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  task automatic clear_prog();
    for (int p = 0; p < N_CREG; p++) begin
      for (int r = 0; r < N_ROW; r++) begin
        for (int c = 0; c < N_COL; c++) begin
          prog[p][r][c] = '0;
        end
      end
    end
  endtask

  // Run limit from the step count and the program loads
  initial begin
    #((N_STEPS * STEP_BOUND + N_LOADS * 30 + 20) * 20);
    $display("Watchdog timeout: the run did not finish in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int e0;
    void'($urandom(32'he5959bc2));
    arst_n_i = 1'b0;
    conf_we_i = '0;
    pc_i = '0;
    pc_en_i = 1'b0;
    data_gnt_i = '0;
    data_rvalid_i = '0;
    run_en = 1'b0;
    delay_en = 1'b0;
    errors = 0;
    tests = 0;
    failed = 0;
    grants = 0;
    for (int r = 0; r < N_ROW; r++) begin
      conf_words_i[r] = '0;
    end
    for (int c = 0; c < N_COL; c++) begin
      data_rdata_i[c] = '0;
      rd_addr[c] = '0;
      for (int a = 0; a < 256; a++) begin
        mem[c][a] = dp_word_t'(a * 257 + c * 4099);
        model_mem[c][a] = mem[c][a];
      end
    end
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        model_res[r][c] = '0;
      end
    end
    clear_prog();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // Idle array after reset
    e0 = errors;
    @(negedge clk_i);
    if (data_req_o != '0 || stall_o) begin
      errors++;
      $display("FAIL %0t: request or stall high after reset", $time);
    end
    run_step(0);
    if (grants != 0) begin
      errors++;
      $display("FAIL %0t: memory traffic from an unconfigured array", $time);
    end
    end_test("reset_idle", e0);

    // ALU ops over all neighbours, then stores
    e0 = errors;
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        prog[0][r][c] = word(1, 5, 0, 3 + 7 * r + 19 * c);
        prog[1][r][c] = word(1 + (r + c) % 5, 1 + (r + 2 * c) % 4,
                             ((r + c) % 2 != 0) ? 5 : 0, 9 * r + c + 1);
        prog[2][r][c] = word(7, 0, 0, 64 + 8 * r + c);
      end
    end
    load_prog();
    for (int p = 0; p < 3; p++) run_step(p);
    end_test("alu_torus", e0);

    // Same program under random grant delay
    e0 = errors;
    delay_en = 1'b1;
    for (int p = 0; p < 3; p++) run_step(p);
    end_test("random_delay", e0);

    // All rows load in one step, then store what they loaded
    e0 = errors;
    clear_prog();
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        prog[0][r][c] = word(6, 0, 0, 5 + r);
        prog[1][r][c] = word(7, 0, 0, 100 + r);
      end
    end
    load_prog();
    run_step(0);
    run_step(1);
    end_test("multi_load", e0);

    // NOP and SWI keep the result registers
    // Their operand A differs from the own register
    e0 = errors;
    clear_prog();
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        prog[0][r][c] = word(1, 5, 5, 11 + r + 3 * c);
        prog[1][r][c] = word(0, 5, 0, 85);
        prog[2][r][c] = word(7, 1, 0, 20 + r);
        prog[3][r][c] = word(7, 0, 0, 24 + r);
        prog[4][r][c] = word(0, 5, 0, 85);
        prog[5][r][c] = word(7, 0, 0, 28 + r);
      end
    end
    load_prog();
    for (int p = 0; p < 6; p++) run_step(p);
    end_test("nop_swi_keep", e0);

    // Random programs of all opcodes
    for (int k = 0; k < 3; k++) begin
      e0 = errors;
      for (int p = 0; p < N_CREG; p++) begin
        for (int r = 0; r < N_ROW; r++) begin
          for (int c = 0; c < N_COL; c++) begin
            prog[p][r][c] = word($urandom % 8, $urandom % 8, $urandom % 8, $urandom % 128);
          end
        end
      end
      load_prog();
      for (int p = 0; p < N_CREG; p++) run_step(p);
      end_test("random_program", e0);
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/cgra_pkg.sv
design/rc_alu.sv
design/reconfigurable_cell.sv
design/rc_mem_arbiter.sv
design/rc_result_regs.sv
design/cgra_array.sv
verification/cgra_array_properties.sv
verification/tb_cgra_array.sv
